//--- src/arb_pkg.sv
package arb_pkg;

    // master side
    localparam int NUM_MASTERS = 4;
    localparam int ID_W        = 2;                    // log2 of NUM_MASTERS
    localparam int PAYLOAD_W   = 53;                   // packed AR/AW fields

    // guard gap between two downstream transfers
    localparam int ARB_GAP     = 4;
    localparam int GAP_CNT_W   = $clog2(ARB_GAP);
    localparam logic [GAP_CNT_W-1:0] GAP_LAST = GAP_CNT_W'(ARB_GAP - 1);

    // response routing FIFO
    localparam int FIFO_DEPTH  = 4;
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W  = FIFO_PTR_W + 1;       // holds 0..FIFO_DEPTH
    localparam logic [FIFO_CNT_W-1:0] FIFO_FULL_CNT = FIFO_CNT_W'(FIFO_DEPTH);

    // controller phases
    typedef enum logic [1:0]
    {
        ST_ARB  = 2'b00,                               // waiting for a request
        ST_XFER = 2'b01,                               // payload offered downstream
        ST_GAP  = 2'b10                                // idle guard cycles
    } arb_state_e;

endpackage

//--- src/arb_ctrl.sv
`timescale 1ns/100ps

module arb_ctrl
(
    input  logic clk,
    input  logic rst_n,
    input  logic grant_valid,                          // arbiter found a request
    input  logic xfer_done,                            // downstream handshake
    input  logic fifo_full,                            // no room for another grant id
    output logic arb_en
);

    arb_pkg::arb_state_e                 state;
    logic [arb_pkg::GAP_CNT_W-1:0]       gap_cnt;

    // only arbitrate when the response FIFO can take the grant id
    assign arb_en = (state == arb_pkg::ST_ARB) && !fifo_full;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= arb_pkg::ST_ARB;
        end
        else
        begin
            case (state)
                arb_pkg::ST_ARB:
                begin
                    if (grant_valid)
                        state <= arb_pkg::ST_XFER;
                end
                arb_pkg::ST_XFER:
                begin
                    if (xfer_done)                     // m_ready back-pressure holds us here
                        state <= arb_pkg::ST_GAP;
                end
                arb_pkg::ST_GAP:
                begin
                    if (gap_cnt == arb_pkg::GAP_LAST)
                        state <= arb_pkg::ST_ARB;
                end
                default:
                    state <= arb_pkg::ST_ARB;
            endcase
        end
    end

    // counts the idle cycles spent in ST_GAP
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            gap_cnt <= '0;
        else if (state == arb_pkg::ST_GAP)
            gap_cnt <= gap_cnt + 1'b1;                 // wraps to 0 on the last gap cycle
        else
            gap_cnt <= '0;
    end

endmodule

//--- src/rr_arbiter.sv
`timescale 1ns/100ps

module rr_arbiter
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             arb_en,
    input  logic [arb_pkg::NUM_MASTERS-1:0]  s_valid,
    output logic [arb_pkg::NUM_MASTERS-1:0]  grant_onehot,
    output logic [arb_pkg::ID_W-1:0]         grant_sel,
    output logic                             grant_valid
);

    logic [arb_pkg::NUM_MASTERS-1:0] req;
    logic [arb_pkg::ID_W-1:0]        prio_ptr;         // highest priority master
    logic [arb_pkg::ID_W-1:0]        scan_idx;

    assign req = arb_en ? s_valid : '0;

    // first active request at or after the pointer wins
    always_comb
    begin
        grant_onehot = '0;
        grant_sel    = '0;
        grant_valid  = 1'b0;
        scan_idx     = prio_ptr;
        for (int i = 0; i < arb_pkg::NUM_MASTERS; i++)
        begin
            scan_idx = prio_ptr + i[arb_pkg::ID_W-1:0]; // wraps modulo master count
            if (req[scan_idx] && !grant_valid)
            begin
                grant_valid            = 1'b1;
                grant_sel              = scan_idx;
                grant_onehot[scan_idx] = 1'b1;
            end
        end
    end

    // winner drops to lowest priority
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            prio_ptr <= '0;
        else if (grant_valid)
            prio_ptr <= grant_sel + 1'b1;
    end

endmodule

//--- src/addr_out_stage.sv
`timescale 1ns/100ps

module addr_out_stage
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [arb_pkg::PAYLOAD_W-1:0]    s0_payload,
    input  logic [arb_pkg::PAYLOAD_W-1:0]    s1_payload,
    input  logic [arb_pkg::PAYLOAD_W-1:0]    s2_payload,
    input  logic [arb_pkg::PAYLOAD_W-1:0]    s3_payload,
    input  logic [arb_pkg::NUM_MASTERS-1:0]  grant_onehot,
    input  logic [arb_pkg::ID_W-1:0]         grant_sel,
    input  logic                             grant_valid,
    input  logic                             m_ready,
    output logic [arb_pkg::NUM_MASTERS-1:0]  s_ready,
    output logic [arb_pkg::PAYLOAD_W-1:0]    m_payload,
    output logic [arb_pkg::ID_W-1:0]         m_id,
    output logic                             m_valid,
    output logic                             xfer_done,
    output logic                             fifo_push,
    output logic [arb_pkg::ID_W-1:0]         push_id
);

    logic [arb_pkg::PAYLOAD_W-1:0] sel_payload;

    always_comb
    begin
        case (grant_sel)
            2'd0:    sel_payload = s0_payload;
            2'd1:    sel_payload = s1_payload;
            2'd2:    sel_payload = s2_payload;
            default: sel_payload = s3_payload;
        endcase
    end

    assign xfer_done = m_valid && m_ready;
    assign push_id   = m_id;                           // id stays valid while fifo_push is high

    // captured once per grant, held until the downstream handshake
    always_ff @(posedge clk)
    begin
        if (grant_valid)
        begin
            m_payload <= sel_payload;
            m_id      <= grant_sel;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            s_ready   <= '0;
            m_valid   <= 1'b0;
            fifo_push <= 1'b0;
        end
        else
        begin
            s_ready   <= grant_onehot;                 // one-cycle ready to the winner
            fifo_push <= grant_valid;
            if (m_valid)
                m_valid <= !m_ready;
            else
                m_valid <= grant_valid;
        end
    end

endmodule

//--- src/resp_route_fifo.sv
`timescale 1ns/100ps

module resp_route_fifo
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             fifo_push,
    input  logic [arb_pkg::ID_W-1:0]         push_id,
    input  logic                             r_valid,
    input  logic                             r_last,
    input  logic [arb_pkg::NUM_MASTERS-1:0]  resp_ready,
    output logic                             fifo_full,
    output logic                             r_ready,
    output logic [arb_pkg::NUM_MASTERS-1:0]  resp_valid
);

    logic [arb_pkg::ID_W-1:0]       id_mem [arb_pkg::FIFO_DEPTH];
    logic [arb_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [arb_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [arb_pkg::FIFO_CNT_W-1:0] count;
    logic [arb_pkg::ID_W-1:0]       head_id;
    logic                           fifo_empty;
    logic                           push;
    logic                           pop;

    assign fifo_empty = (count == '0);
    assign fifo_full  = (count == arb_pkg::FIFO_FULL_CNT);
    assign head_id    = id_mem[rd_ptr];

    // steer the response to the owner of the oldest grant
    always_comb
    begin
        resp_valid = '0;
        r_ready    = 1'b0;
        if (!fifo_empty)
        begin
            resp_valid[head_id] = r_valid;
            r_ready             = resp_ready[head_id];
        end
    end

    assign push = fifo_push && !fifo_full;
    assign pop  = r_valid && r_ready && r_last;        // retire after the last beat

    always_ff @(posedge clk)
    begin
        if (push)
            id_mem[wr_ptr] <= push_id;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;               // both or neither
            endcase
        end
    end

endmodule

//--- src/addr_arb_top.sv
`timescale 1ns/100ps

module addr_arb_top
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [arb_pkg::PAYLOAD_W-1:0]    s0_payload,
    input  logic [arb_pkg::PAYLOAD_W-1:0]    s1_payload,
    input  logic [arb_pkg::PAYLOAD_W-1:0]    s2_payload,
    input  logic [arb_pkg::PAYLOAD_W-1:0]    s3_payload,
    input  logic [arb_pkg::NUM_MASTERS-1:0]  s_valid,
    output logic [arb_pkg::NUM_MASTERS-1:0]  s_ready,
    output logic [arb_pkg::PAYLOAD_W-1:0]    m_payload,
    output logic [arb_pkg::ID_W-1:0]         m_id,
    output logic                             m_valid,
    input  logic                             m_ready,
    input  logic                             r_valid,
    input  logic                             r_last,
    output logic                             r_ready,
    output logic [arb_pkg::NUM_MASTERS-1:0]  resp_valid,
    input  logic [arb_pkg::NUM_MASTERS-1:0]  resp_ready
);

    logic                            arb_en;
    logic [arb_pkg::NUM_MASTERS-1:0] grant_onehot;
    logic [arb_pkg::ID_W-1:0]        grant_sel;
    logic                            grant_valid;
    logic                            xfer_done;
    logic                            fifo_push;
    logic [arb_pkg::ID_W-1:0]        push_id;
    logic                            fifo_full;

    arb_ctrl u_ctrl
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .grant_valid (grant_valid),
        .xfer_done   (xfer_done),
        .fifo_full   (fifo_full),
        .arb_en      (arb_en)
    );

    rr_arbiter u_arbiter
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .arb_en       (arb_en),
        .s_valid      (s_valid),
        .grant_onehot (grant_onehot),
        .grant_sel    (grant_sel),
        .grant_valid  (grant_valid)
    );

    addr_out_stage u_out_stage
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .s0_payload   (s0_payload),
        .s1_payload   (s1_payload),
        .s2_payload   (s2_payload),
        .s3_payload   (s3_payload),
        .grant_onehot (grant_onehot),
        .grant_sel    (grant_sel),
        .grant_valid  (grant_valid),
        .m_ready      (m_ready),
        .s_ready      (s_ready),
        .m_payload    (m_payload),
        .m_id         (m_id),
        .m_valid      (m_valid),
        .xfer_done    (xfer_done),
        .fifo_push    (fifo_push),
        .push_id      (push_id)
    );

    resp_route_fifo u_resp_fifo
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .fifo_push  (fifo_push),
        .push_id    (push_id),
        .r_valid    (r_valid),
        .r_last     (r_last),
        .resp_ready (resp_ready),
        .fifo_full  (fifo_full),
        .r_ready    (r_ready),
        .resp_valid (resp_valid)
    );

endmodule

//--- sim/addr_arb_asserts.sv
`timescale 1ns/100ps

module addr_arb_asserts
(
    input logic                             clk,
    input logic                             rst_n,
    input logic                             m_valid,
    input logic                             m_ready,
    input logic [arb_pkg::PAYLOAD_W-1:0]    m_payload,
    input logic [arb_pkg::ID_W-1:0]         m_id,
    input logic [arb_pkg::NUM_MASTERS-1:0]  s_ready,
    input logic [arb_pkg::NUM_MASTERS-1:0]  resp_valid,
    input logic [1:0]                       state
);

    // downstream offer is held until accepted
    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid && !m_ready |=> $stable(m_payload) && $stable(m_id))
        else $error("m_payload or m_id changed while stalled");

    ready_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(s_ready))
        else $error("s_ready has more than one bit set");

    state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {arb_pkg::ST_ARB, arb_pkg::ST_XFER, arb_pkg::ST_GAP})
        else $error("controller state outside the enum");

    resp_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(resp_valid))
        else $error("resp_valid has more than one bit set");

endmodule

bind addr_arb_top addr_arb_asserts u_asserts
(
    .clk        (clk),
    .rst_n      (rst_n),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .m_payload  (m_payload),
    .m_id       (m_id),
    .s_ready    (s_ready),
    .resp_valid (resp_valid),
    .state      (u_ctrl.state)
);

//--- sim/tb_addr_arb.sv
`timescale 1ns/100ps

module tb_addr_arb;

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic [arb_pkg::PAYLOAD_W-1:0]   pay [arb_pkg::NUM_MASTERS];
    logic [arb_pkg::NUM_MASTERS-1:0] s_valid;
    logic [arb_pkg::NUM_MASTERS-1:0] s_ready;
    logic [arb_pkg::PAYLOAD_W-1:0]   m_payload;
    logic [arb_pkg::ID_W-1:0]        m_id;
    logic                            m_valid;
    logic                            m_ready;
    logic                            r_valid;
    logic                            r_last;
    logic                            r_ready;
    logic [arb_pkg::NUM_MASTERS-1:0] resp_valid;
    logic [arb_pkg::NUM_MASTERS-1:0] resp_ready;

    int                              cyc = 0;
    int                              last_hs = -100;   // cycle of last downstream handshake
    int                              rr_ptr = 0;       // model priority pointer
    int                              exp_q[$];         // model of outstanding grant ids
    logic [arb_pkg::NUM_MASTERS-1:0] pending;

    always #20 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    addr_arb_top UUT
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .s0_payload (pay[0]),
        .s1_payload (pay[1]),
        .s2_payload (pay[2]),
        .s3_payload (pay[3]),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .m_payload  (m_payload),
        .m_id       (m_id),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .r_valid    (r_valid),
        .r_last     (r_last),
        .r_ready    (r_ready),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp)
        else
            report_failure($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    // round-robin pick from the model pointer
    function automatic int next_winner(input logic [arb_pkg::NUM_MASTERS-1:0] mask);
        int idx;
        for (int i = 0; i < arb_pkg::NUM_MASTERS; i++)
        begin
            idx = (rr_ptr + i) % arb_pkg::NUM_MASTERS;
            if (mask[idx])
                return idx;
        end
        return -1;
    endfunction

    task automatic serve_response();
        int  head;
        int  beats;
        int  t;
        logic done;
        if (exp_q.size() == 0)
            report_failure("Response started with no outstanding grant");
        head  = exp_q[0];
        beats = $urandom_range(1, 2);
        @(posedge clk);
        #2;
        for (int b = 0; b < beats; b++)
        begin
            r_valid    = 1'b1;
            r_last     = (b == beats - 1);
            resp_ready = $urandom_range(0, 15);         // random stalls on the masters
            done       = 1'b0;
            t          = 0;
            while (!done)
            begin
                @(negedge clk);
                check_val("resp_valid", resp_valid, 64'(1) << head);
                check_val("r_ready", r_ready, resp_ready[head]);
                done = r_ready;
                if (!done)
                begin
                    t++;
                    if (t > 100)
                        report_failure("Timeout waiting for r_ready");
                    @(posedge clk);
                    #2;
                    resp_ready = $urandom_range(0, 15);
                end
            end
            @(posedge clk);
            #2;
        end
        r_valid    = 1'b0;
        r_last     = 1'b0;
        resp_ready = '0;
        void'(exp_q.pop_front());                      // last beat retires the entry
        @(negedge clk);
        check_val("resp_valid", resp_valid, 0);
    endtask

    // FIFO full, so nothing may be granted
    task automatic check_blocked();
        repeat (8)
        begin
            @(negedge clk);
            check_val("s_ready", s_ready, 0);
            check_val("m_valid", m_valid, 0);
        end
        serve_response();
    endtask

    task automatic wait_grant(input int stall);
        int                            t;
        int                            id;
        t = 0;
        @(negedge clk);
        while (!m_valid)
        begin
            t++;
            if (t > 200)
                report_failure("Timeout waiting for m_valid");
            @(negedge clk);
        end
        assert (cyc - last_hs >= arb_pkg::ARB_GAP + 2)
        else
            report_failure($sformatf("Fail at %0t: m_valid gap is %0d cycles, expected >= %0d",
                                     $time, cyc - last_hs, arb_pkg::ARB_GAP + 2));
        id = next_winner(pending);
        if (id < 0)
            report_failure("Grant issued with no pending request");
        check_val("m_id", m_id, id);
        check_val("m_payload", m_payload, pay[id]);
        check_val("s_ready", s_ready, 64'(1) << id);
        rr_ptr      = (id + 1) % arb_pkg::NUM_MASTERS;
        pending[id] = 1'b0;
        exp_q.push_back(id);
        @(posedge clk);
        #2;
        s_valid[id] = 1'b0;                            // upstream transfer done
        for (int k = 0; k < stall; k++)
        begin
            @(negedge clk);
            check_val("m_valid", m_valid, 1);
            check_val("m_payload", m_payload, pay[id]);
            check_val("s_ready", s_ready, 0);
            @(posedge clk);
            #2;
        end
        m_ready = 1'b1;
        @(negedge clk);
        check_val("m_valid", m_valid, 1);
        check_val("m_payload", m_payload, pay[id]);
        last_hs = cyc;
        @(posedge clk);
        #2;
        m_ready = 1'b0;
    endtask

    initial
    begin
        int                              fd;
        int                              n;
        int                              lines;
        int                              stall;
        int                              hold;
        string                           line;
        logic [arb_pkg::NUM_MASTERS-1:0] mask;
        logic [arb_pkg::PAYLOAD_W-1:0]   p [arb_pkg::NUM_MASTERS];
        void'($urandom(39));
        rst_n      = 1'b0;
        s_valid    = '0;
        m_ready    = 1'b0;
        r_valid    = 1'b0;
        r_last     = 1'b0;
        resp_ready = '0;
        pending    = '0;
        lines      = 0;
        for (int i = 0; i < arb_pkg::NUM_MASTERS; i++)
            pay[i] = '0;
        fd = $fopen("sim/arb_stim.txt", "r");
        if (fd == 0)
            report_failure("Cannot open sim/arb_stim.txt");
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_val("s_ready", s_ready, 0);
        check_val("m_valid", m_valid, 0);
        check_val("r_ready", r_ready, 0);
        check_val("resp_valid", resp_valid, 0);
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h", mask, p[0], p[1], p[2], p[3], stall, hold);
            if (n != 7)
                report_failure("Malformed line in sim/arb_stim.txt");
            lines++;
            @(posedge clk);
            #2;
            for (int i = 0; i < arb_pkg::NUM_MASTERS; i++)
                pay[i] = p[i];
            s_valid = mask;
            pending = mask;
            while (pending != 0)
            begin
                if (exp_q.size() == arb_pkg::FIFO_DEPTH)
                    check_blocked();
                wait_grant(stall);
            end
            if (hold == 0)
            begin
                while (exp_q.size() > 0)
                    serve_response();
            end
        end
        $fclose(fd);
        while (exp_q.size() > 0)
            serve_response();
        if (lines > 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            report_failure("No stimulus lines were read");
        end
        $finish;
    end

endmodule

//--- project.f
src/arb_pkg.sv
src/arb_ctrl.sv
src/rr_arbiter.sv
src/addr_out_stage.sv
src/resp_route_fifo.sv
src/addr_arb_top.sv
sim/addr_arb_asserts.sv
sim/tb_addr_arb.sv

//--- Bender.yml
package:
  name: addr_arb

sources:
  - src/arb_pkg.sv
  - src/arb_ctrl.sv
  - src/rr_arbiter.sv
  - src/addr_out_stage.sv
  - src/resp_route_fifo.sv
  - src/addr_arb_top.sv
  - target: simulation
    files:
      - sim/addr_arb_asserts.sv
      - sim/tb_addr_arb.sv

//--- sim/arb_stim.txt
# columns (hex): request mask, payload m0, payload m1, payload m2, payload m3,
# m_ready stall cycles, responses withheld flag
f 00000000001000 00000000002111 00000000003222 00000000004333 0 0
f 1abcdef0123456 0fedcba9876543 12345678abcdef 00000000000001 3 0
5 1fffffffffffff 00000000000000 0aaaaaaaaaaaaa 15555555555555 1 0
a 0123456789abcd 1dcba987654321 00000000c0ffee 0000000badcafe 0 0
f 10000000000010 10000000000021 10000000000032 10000000000043 2 1
3 0f0f0f0f0f0f0f 10f0f0f0f0f0f0 00ff00ff00ff00 1ff00ff00ff00f 0 1
e 00000000000abc 00000000000def 00000000000123 00000000000456 1 0
1 1e1e1e1e1e1e1e 00000000000000 00000000000000 00000000000000 0 0
8 00000000000000 00000000000000 00000000000000 0b0b0b0b0b0b0b 4 0
